// File: stream_pkg.sv
/* Stream widths and data types shared by the physical ports and the core */

`default_nettype none

package stream_pkg;

    //////////////////////////////
    // Widths

    // One byte per physical beat
    localparam int PHYS_DATA_BYTES = 1;

    // Core word carries four beats
    localparam int CORE_DATA_BYTES = 4;

    //////////////////////////////
    // Types

    typedef logic [PHYS_DATA_BYTES*8-1:0] phys_data_t;

    // Byte 0 is the earliest byte and sits in the low bits
    typedef logic [CORE_DATA_BYTES*8-1:0] core_data_t;

    // Valid bytes in a core word from 1 to 4
    typedef logic [2:0] byte_cnt_t;

endpackage

`default_nettype wire

// File: stats_pkg.sv
/* Frame counter width and type */

`default_nettype none

package stats_pkg;

    //////////////////////////////
    // Frame counters

    localparam int FRAME_CNT_WIDTH = 32;

    // Wraps silently at the top
    typedef logic [FRAME_CNT_WIDTH-1:0] frame_cnt_t;

endpackage

`default_nettype wire

// File: ing_port_packer.sv
/* Ingress packer for one physical port
   Collects 8-bit beats into core words and holds each word for the switch */

`timescale 1ns/1ps
`default_nettype none

module ing_port_packer
    import stream_pkg::*;
(
    input  wire             phys_port_clk_ifc,
    input  wire             rst_n,
    input  wire phys_data_t ing_tdata,
    input  wire             ing_tvalid,
    input  wire             ing_tlast,
    output logic            ing_tready,
    output core_data_t      pk_data,
    output byte_cnt_t       pk_bytes,
    output logic            pk_last,
    output logic            pk_valid,
    input  wire             pk_ready
);

    localparam int BEATS  = CORE_DATA_BYTES / PHYS_DATA_BYTES;
    localparam int FILL_W = $clog2(BEATS);
    localparam int PHYS_W = PHYS_DATA_BYTES * 8;

    logic [FILL_W-1:0] fill;
    logic              beat;
    logic              close;

    // Word register frees up in the same cycle the switch takes it
    assign ing_tready = !pk_valid || pk_ready;
    assign beat       = ing_tvalid && ing_tready;
    assign close      = beat && (ing_tlast || fill == FILL_W'(BEATS - 1));

    always_ff @(posedge phys_port_clk_ifc or negedge rst_n) begin
        if (!rst_n) begin
            fill     <= '0;
            pk_valid <= 1'b0;
        end else if (close) begin
            fill     <= '0;
            pk_valid <= 1'b1;
        end else begin
            if (beat) begin
                fill <= fill + 1'b1;
            end
            if (pk_valid && pk_ready) begin
                pk_valid <= 1'b0;
            end
        end
    end

    // First beat clears the upper bytes of the word
    always_ff @(posedge phys_port_clk_ifc) begin
        if (beat) begin
            if (fill == '0) begin
                pk_data <= core_data_t'(ing_tdata);
            end else begin
                pk_data[fill*PHYS_W +: PHYS_W] <= ing_tdata;
            end
        end
        if (close) begin
            pk_bytes <= byte_cnt_t'(fill) + byte_cnt_t'(1);
            pk_last  <= ing_tlast;
        end
    end

    // Word held while the switch stalls
    assert property (@(posedge phys_port_clk_ifc) disable iff (!rst_n)
        pk_valid && !pk_ready |=> $stable(pk_data));

endmodule

`default_nettype wire

// File: echo_switch.sv
/* Packet round-robin arbiter over the ingress packers
   and demultiplexer back to the egress port with the same index */

`timescale 1ns/1ps
`default_nettype none

module echo_switch
    import stream_pkg::*;
#(
    parameter int NUM_PORTS = 4
) (
    input  wire                  phys_port_clk_ifc,
    input  wire                  rst_n,
    input  wire core_data_t      pk_data  [NUM_PORTS],
    input  wire byte_cnt_t       pk_bytes [NUM_PORTS],
    input  wire [NUM_PORTS-1:0]  pk_last,
    input  wire [NUM_PORTS-1:0]  pk_valid,
    output logic [NUM_PORTS-1:0] pk_ready,
    output core_data_t           sw_data,
    output byte_cnt_t            sw_bytes,
    output logic                 sw_last,
    output logic [NUM_PORTS-1:0] sw_valid,
    input  wire [NUM_PORTS-1:0]  sw_ready
);

    localparam int IDX_W = $clog2(NUM_PORTS);

    logic             locked;
    logic [IDX_W-1:0] grant;
    logic [IDX_W-1:0] rr_ptr;
    logic [IDX_W-1:0] pick;
    logic             found;
    logic [IDX_W-1:0] sel;
    logic             active;
    logic             xfer;

    // First requester at or after the round-robin pointer
    always_comb begin : rr_search
        int idx;
        found = 1'b0;
        pick  = rr_ptr;
        for (int k = 0; k < NUM_PORTS; k++) begin
            idx = int'(rr_ptr) + k;
            if (idx >= NUM_PORTS) begin
                idx = idx - NUM_PORTS;
            end
            if (!found && pk_valid[idx]) begin
                found = 1'b1;
                pick  = IDX_W'(idx);
            end
        end
    end

    assign sel    = locked ? grant : pick;
    assign active = locked || found;
    assign xfer   = active && pk_valid[sel] && sw_ready[sel];

    assign sw_data  = pk_data[sel];
    assign sw_bytes = pk_bytes[sel];
    assign sw_last  = pk_last[sel];

    // Egress index equals ingress index
    always_comb begin
        for (int i = 0; i < NUM_PORTS; i++) begin
            sw_valid[i] = active && (sel == IDX_W'(i)) && pk_valid[i];
            pk_ready[i] = active && (sel == IDX_W'(i)) && sw_ready[i];
        end
    end

    //////////////////////////////
    // Packet lock

    always_ff @(posedge phys_port_clk_ifc or negedge rst_n) begin
        if (!rst_n) begin
            locked <= 1'b0;
            grant  <= '0;
            rr_ptr <= '0;
        end else if (active) begin
            if (xfer && sw_last) begin
                locked <= 1'b0;
                rr_ptr <= (sel == IDX_W'(NUM_PORTS - 1)) ? '0 : sel + 1'b1;
            end else begin
                locked <= 1'b1;
                grant  <= sel;
            end
        end
    end

    // Only one egress port sees a word at a time
    assert property (@(posedge phys_port_clk_ifc) disable iff (!rst_n)
        $onehot0(sw_valid));

endmodule

`default_nettype wire

// File: egr_port_unpacker.sv
/* Egress unpacker for one physical port
   Splits a core word into 8-bit beats, low byte first */

`timescale 1ns/1ps
`default_nettype none

module egr_port_unpacker
    import stream_pkg::*;
(
    input  wire             phys_port_clk_ifc,
    input  wire             rst_n,
    input  wire core_data_t sw_data,
    input  wire byte_cnt_t  sw_bytes,
    input  wire             sw_last,
    input  wire             sw_valid,
    output logic            sw_ready,
    output phys_data_t      egr_tdata,
    output logic            egr_tvalid,
    output logic            egr_tlast,
    input  wire             egr_tready
);

    localparam int PHYS_W = PHYS_DATA_BYTES * 8;

    core_data_t word;
    byte_cnt_t  remain;
    logic       word_last;
    logic       take;
    logic       emit;

    // Next word only once the current one is drained
    assign sw_ready   = (remain == '0);
    assign take       = sw_valid && sw_ready;
    assign egr_tvalid = (remain != '0);
    assign emit       = egr_tvalid && egr_tready;
    assign egr_tdata  = word[PHYS_W-1:0];
    assign egr_tlast  = word_last && (remain == byte_cnt_t'(1));

    always_ff @(posedge phys_port_clk_ifc or negedge rst_n) begin
        if (!rst_n) begin
            remain <= '0;
        end else if (take) begin
            remain <= sw_bytes;
        end else if (emit) begin
            remain <= remain - 1'b1;
        end
    end

    always_ff @(posedge phys_port_clk_ifc) begin
        if (take) begin
            word      <= sw_data;
            word_last <= sw_last;
        end else if (emit) begin
            word <= word >> PHYS_W;
        end
    end

    // Packer never closes an empty word
    assert property (@(posedge phys_port_clk_ifc) disable iff (!rst_n)
        take |-> sw_bytes != '0);

endmodule

`default_nettype wire

// File: port_frame_counters.sv
/* Per-port completed-frame counters with synchronous clear */

`timescale 1ns/1ps
`default_nettype none

module port_frame_counters
    import stats_pkg::*;
#(
    parameter int NUM_PORTS = 4
) (
    input  wire                 phys_port_clk_ifc,
    input  wire                 rst_n,
    input  wire [NUM_PORTS-1:0] tvalid,
    input  wire [NUM_PORTS-1:0] tready,
    input  wire [NUM_PORTS-1:0] tlast,
    input  wire [NUM_PORTS-1:0] cnt_clear,
    output frame_cnt_t          frame_cnt [NUM_PORTS]
);

    for (genvar i = 0; i < NUM_PORTS; i++) begin : g_port
        // Clear wins over a count in the same cycle
        always_ff @(posedge phys_port_clk_ifc or negedge rst_n) begin
            if (!rst_n) begin
                frame_cnt[i] <= '0;
            end else if (cnt_clear[i]) begin
                frame_cnt[i] <= '0;
            end else if (tvalid[i] && tready[i] && tlast[i]) begin
                frame_cnt[i] <= frame_cnt[i] + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// File: p4_router_top.sv
/* Router top level with ingress packers, echo switch,
   egress unpackers and frame counters */

`timescale 1ns/1ps
`default_nettype none

module p4_router_top
    import stream_pkg::*;
    import stats_pkg::*;
#(
    parameter int NUM_PORTS = 4
) (
    input  wire                 phys_port_clk_ifc,
    input  wire                 rst_n,
    input  wire phys_data_t     ing_tdata  [NUM_PORTS],
    input  wire [NUM_PORTS-1:0] ing_tvalid,
    input  wire [NUM_PORTS-1:0] ing_tlast,
    output wire [NUM_PORTS-1:0] ing_tready,
    output wire phys_data_t     egr_tdata  [NUM_PORTS],
    output wire [NUM_PORTS-1:0] egr_tvalid,
    output wire [NUM_PORTS-1:0] egr_tlast,
    input  wire [NUM_PORTS-1:0] egr_tready,
    input  wire [NUM_PORTS-1:0] cnt_clear,
    output wire frame_cnt_t     ing_frame_cnt [NUM_PORTS],
    output wire frame_cnt_t     egr_frame_cnt [NUM_PORTS]
);

    wire core_data_t     pk_data  [NUM_PORTS];
    wire byte_cnt_t      pk_bytes [NUM_PORTS];
    wire [NUM_PORTS-1:0] pk_last;
    wire [NUM_PORTS-1:0] pk_valid;
    wire [NUM_PORTS-1:0] pk_ready;
    wire core_data_t     sw_data;
    wire byte_cnt_t      sw_bytes;
    wire                 sw_last;
    wire [NUM_PORTS-1:0] sw_valid;
    wire [NUM_PORTS-1:0] sw_ready;

    //////////////////////////////
    // Port datapath

    for (genvar i = 0; i < NUM_PORTS; i++) begin : g_port
        ing_port_packer u_packer (
            .phys_port_clk_ifc (phys_port_clk_ifc),
            .rst_n             (rst_n),
            .ing_tdata         (ing_tdata[i]),
            .ing_tvalid        (ing_tvalid[i]),
            .ing_tlast         (ing_tlast[i]),
            .ing_tready        (ing_tready[i]),
            .pk_data           (pk_data[i]),
            .pk_bytes          (pk_bytes[i]),
            .pk_last           (pk_last[i]),
            .pk_valid          (pk_valid[i]),
            .pk_ready          (pk_ready[i])
        );

        // Shared switch bus qualified per port by sw_valid
        egr_port_unpacker u_unpacker (
            .phys_port_clk_ifc (phys_port_clk_ifc),
            .rst_n             (rst_n),
            .sw_data           (sw_data),
            .sw_bytes          (sw_bytes),
            .sw_last           (sw_last),
            .sw_valid          (sw_valid[i]),
            .sw_ready          (sw_ready[i]),
            .egr_tdata         (egr_tdata[i]),
            .egr_tvalid        (egr_tvalid[i]),
            .egr_tlast         (egr_tlast[i]),
            .egr_tready        (egr_tready[i])
        );
    end

    echo_switch #(
        .NUM_PORTS (NUM_PORTS)
    ) u_switch (
        .phys_port_clk_ifc (phys_port_clk_ifc),
        .rst_n             (rst_n),
        .pk_data           (pk_data),
        .pk_bytes          (pk_bytes),
        .pk_last           (pk_last),
        .pk_valid          (pk_valid),
        .pk_ready          (pk_ready),
        .sw_data           (sw_data),
        .sw_bytes          (sw_bytes),
        .sw_last           (sw_last),
        .sw_valid          (sw_valid),
        .sw_ready          (sw_ready)
    );

    //////////////////////////////
    // Frame counters

    port_frame_counters #(
        .NUM_PORTS (NUM_PORTS)
    ) u_ing_cnt (
        .phys_port_clk_ifc (phys_port_clk_ifc),
        .rst_n             (rst_n),
        .tvalid            (ing_tvalid),
        .tready            (ing_tready),
        .tlast             (ing_tlast),
        .cnt_clear         (cnt_clear),
        .frame_cnt         (ing_frame_cnt)
    );

    port_frame_counters #(
        .NUM_PORTS (NUM_PORTS)
    ) u_egr_cnt (
        .phys_port_clk_ifc (phys_port_clk_ifc),
        .rst_n             (rst_n),
        .tvalid            (egr_tvalid),
        .tready            (egr_tready),
        .tlast             (egr_tlast),
        .cnt_clear         (cnt_clear),
        .frame_cnt         (egr_frame_cnt)
    );

endmodule

`default_nettype wire

// File: p4_router_checker.sv
/* Packet checker for the router testbench
   Compares ingress and egress byte streams per port and the frame counters */

`timescale 1ns/1ps
`default_nettype none

module p4_router_checker
    import stream_pkg::*;
    import stats_pkg::*;
#(
    parameter int NUM_PORTS = 4
) (
    input wire                 phys_port_clk_ifc,
    input wire                 rst_n,
    input wire phys_data_t     ing_tdata [NUM_PORTS],
    input wire [NUM_PORTS-1:0] ing_tvalid,
    input wire [NUM_PORTS-1:0] ing_tlast,
    input wire [NUM_PORTS-1:0] ing_tready,
    input wire phys_data_t     egr_tdata [NUM_PORTS],
    input wire [NUM_PORTS-1:0] egr_tvalid,
    input wire [NUM_PORTS-1:0] egr_tlast,
    input wire [NUM_PORTS-1:0] egr_tready,
    input wire frame_cnt_t     ing_frame_cnt [NUM_PORTS],
    input wire frame_cnt_t     egr_frame_cnt [NUM_PORTS]
);

    localparam int DEPTH = 1024;

    // Expected beats per port as {last, data}
    logic [8:0] exp_mem [NUM_PORTS][DEPTH];
    int         wr_ptr [NUM_PORTS];
    int         rd_ptr [NUM_PORTS];
    int         egr_pkts [NUM_PORTS];
    int         exp_frames [NUM_PORTS];
    int         row_errs [NUM_PORTS];
    logic       drop_seen [NUM_PORTS];
    string      cur_name [NUM_PORTS];
    int         errors;
    int         tests;
    int         failed;

    initial begin
        errors = 0;
        tests  = 0;
        failed = 0;
        for (int i = 0; i < NUM_PORTS; i++) begin
            wr_ptr[i]     = 0;
            rd_ptr[i]     = 0;
            egr_pkts[i]   = 0;
            exp_frames[i] = 0;
            row_errs[i]   = 0;
            drop_seen[i]  = 1'b0;
            cur_name[i]   = "idle";
        end
    end

    task automatic note_error(input int p);
        errors++;
        row_errs[p]++;
    endtask

    task automatic compare_beat(input int p);
        logic [8:0] exp;
        logic [8:0] act;
        act = {egr_tlast[p], egr_tdata[p]};
        if (rd_ptr[p] == wr_ptr[p]) begin
            $display("Test %s: port %0d sent an egress byte that never entered ingress",
                     cur_name[p], p);
            note_error(p);
        end else begin
            exp = exp_mem[p][rd_ptr[p] % DEPTH];
            rd_ptr[p]++;
            if (act !== exp) begin
                $display("** Error %s: port %0d expected data %h last %0b, actual data %h last %0b",
                         cur_name[p], p, exp[7:0], exp[8], act[7:0], act[8]);
                note_error(p);
            end
        end
        if (egr_tlast[p]) begin
            egr_pkts[p]++;
        end
    endtask

    ////////////////////////////////
    // Stream monitor

    always @(posedge phys_port_clk_ifc) begin
        if (rst_n) begin
            for (int i = 0; i < NUM_PORTS; i++) begin
                if (!ing_tready[i]) begin
                    drop_seen[i] = 1'b1;
                end
                if (ing_tvalid[i] && ing_tready[i]) begin
                    exp_mem[i][wr_ptr[i] % DEPTH] = {ing_tlast[i], ing_tdata[i]};
                    wr_ptr[i]++;
                end
                if (egr_tvalid[i] && egr_tready[i]) begin
                    compare_beat(i);
                end
            end
        end
    end

    ////////////////////////////////
    // Row bookkeeping

    task automatic start_row(input string name, input int p);
        cur_name[p]  = name;
        row_errs[p]  = 0;
        drop_seen[p] = 1'b0;
    endtask

    function automatic bit count_ok(input string name, input string what, input int p,
                                    input frame_cnt_t act, input int exp);
        if (act !== frame_cnt_t'(exp)) begin
            $display("** Error %s: port %0d %s expected %0d actual %0d",
                     name, p, what, exp, act);
            return 1'b0;
        end
        return 1'b1;
    endfunction

    task automatic report_row(input string name, input int p, input logic stall,
                              input logic clear);
        if (clear) begin
            exp_frames[p] = 0;
        end else begin
            exp_frames[p]++;
        end
        // After a clear the other ports keep their counts
        for (int i = 0; i < NUM_PORTS; i++) begin
            if (clear || i == p) begin
                if (!count_ok(name, "ingress frame count", i, ing_frame_cnt[i], exp_frames[i]))
                    note_error(p);
                if (!count_ok(name, "egress frame count", i, egr_frame_cnt[i], exp_frames[i]))
                    note_error(p);
            end
        end
        if (stall && !drop_seen[p]) begin
            $display("Test %s: ing_tready on port %0d never dropped under egress stalls",
                     name, p);
            note_error(p);
        end
        tests++;
        if (row_errs[p] == 0) begin
            $display("PASS %s", name);
        end else begin
            failed++;
            $display("FAIL %s (%0d errors)", name, row_errs[p]);
        end
        cur_name[p] = "idle";
    endtask

endmodule

`default_nettype wire

// File: p4_router_tb.sv
/* Router testbench with clock, reset, LFSR stimulus,
   test table and per-port packet drivers */

`timescale 1ns/1ps
`default_nettype none

module p4_router_tb
    import stream_pkg::*;
    import stats_pkg::*;
();

    localparam int NUM_PORTS  = 4;
    localparam int CLK_PERIOD = 40;
    localparam int TIMEOUT    = 2000;
    localparam int MAX_ROWS   = 32;
    localparam int MAX_LEN    = 64;

    logic                 phys_port_clk_ifc;
    logic                 rst_n;
    phys_data_t           ing_tdata [NUM_PORTS];
    logic [NUM_PORTS-1:0] ing_tvalid;
    logic [NUM_PORTS-1:0] ing_tlast;
    wire  [NUM_PORTS-1:0] ing_tready;
    wire  phys_data_t     egr_tdata [NUM_PORTS];
    wire  [NUM_PORTS-1:0] egr_tvalid;
    wire  [NUM_PORTS-1:0] egr_tlast;
    logic [NUM_PORTS-1:0] egr_tready;
    logic [NUM_PORTS-1:0] cnt_clear;
    wire  frame_cnt_t     ing_frame_cnt [NUM_PORTS];
    wire  frame_cnt_t     egr_frame_cnt [NUM_PORTS];

    // Test table
    string      row_name  [MAX_ROWS];
    int         row_batch [MAX_ROWS];
    int         row_port  [MAX_ROWS];
    int         row_len   [MAX_ROWS];
    logic       row_stall [MAX_ROWS];
    logic       row_clear [MAX_ROWS];
    phys_data_t payload   [MAX_ROWS][MAX_LEN];
    int         nrows;

    logic [31:0]          lfsr_state;
    logic [NUM_PORTS-1:0] stall_on;
    int                   timeouts;

    p4_router_top #(
        .NUM_PORTS (NUM_PORTS)
    ) u_dut (
        .phys_port_clk_ifc (phys_port_clk_ifc),
        .rst_n             (rst_n),
        .ing_tdata         (ing_tdata),
        .ing_tvalid        (ing_tvalid),
        .ing_tlast         (ing_tlast),
        .ing_tready        (ing_tready),
        .egr_tdata         (egr_tdata),
        .egr_tvalid        (egr_tvalid),
        .egr_tlast         (egr_tlast),
        .egr_tready        (egr_tready),
        .cnt_clear         (cnt_clear),
        .ing_frame_cnt     (ing_frame_cnt),
        .egr_frame_cnt     (egr_frame_cnt)
    );

    p4_router_checker #(
        .NUM_PORTS (NUM_PORTS)
    ) u_chk (
        .phys_port_clk_ifc (phys_port_clk_ifc),
        .rst_n             (rst_n),
        .ing_tdata         (ing_tdata),
        .ing_tvalid        (ing_tvalid),
        .ing_tlast         (ing_tlast),
        .ing_tready        (ing_tready),
        .egr_tdata         (egr_tdata),
        .egr_tvalid        (egr_tvalid),
        .egr_tlast         (egr_tlast),
        .egr_tready        (egr_tready),
        .ing_frame_cnt     (ing_frame_cnt),
        .egr_frame_cnt     (egr_frame_cnt)
    );

    always #(CLK_PERIOD / 2) phys_port_clk_ifc = ~phys_port_clk_ifc;

    ////////////////////////////////
    // Random bits

    // Taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic take_bits(input int n, output logic [7:0] bits);
        bits = '0;
        for (int k = 0; k < n; k++) begin
            lfsr_state = lfsr_next(lfsr_state);
            bits       = {bits[6:0], lfsr_state[0]};
        end
    endtask

    task automatic add_row(input string name, input int batch, input int port,
                           input int len, input logic stall, input logic clear);
        row_name[nrows]  = name;
        row_batch[nrows] = batch;
        row_port[nrows]  = port;
        row_len[nrows]   = len;
        row_stall[nrows] = stall;
        row_clear[nrows] = clear;
        nrows++;
    endtask

    // One random egress stall bit per stalled port per cycle
    initial begin
        logic [7:0] b;
        egr_tready = '1;
        forever begin
            @(posedge phys_port_clk_ifc);
            #1;
            for (int i = 0; i < NUM_PORTS; i++) begin
                if (stall_on[i]) begin
                    take_bits(1, b);
                    egr_tready[i] = b[0];
                end else begin
                    egr_tready[i] = 1'b1;
                end
            end
        end
    end

    ////////////////////////////////
    // Drivers

    task automatic send_packet(input int r, output bit ok);
        int p;
        int n;
        bit taken;
        p  = row_port[r];
        ok = 1'b1;
        for (int b = 0; b < row_len[r] && ok; b++) begin
            ing_tdata[p]  = payload[r][b];
            ing_tvalid[p] = 1'b1;
            ing_tlast[p]  = (b == row_len[r] - 1);
            taken = 1'b0;
            n     = 0;
            while (!taken && n < TIMEOUT) begin
                @(posedge phys_port_clk_ifc);
                taken = ing_tready[p];
                n++;
            end
            #1;
            ok = taken;
        end
        ing_tvalid[p] = 1'b0;
        ing_tlast[p]  = 1'b0;
    endtask

    task automatic pulse_clear(input int p);
        cnt_clear[p] = 1'b1;
        @(posedge phys_port_clk_ifc);
        #1;
        cnt_clear[p] = 1'b0;
    endtask

    task automatic run_row(input int r);
        int p;
        int target;
        int n;
        bit ok;
        p      = row_port[r];
        target = u_chk.egr_pkts[p] + 1;
        u_chk.start_row(row_name[r], p);
        stall_on[p] = row_stall[r];
        send_packet(r, ok);
        n = 0;
        while (ok && u_chk.egr_pkts[p] < target && n < TIMEOUT) begin
            @(posedge phys_port_clk_ifc);
            #1;
            n++;
        end
        stall_on[p] = 1'b0;
        if (!ok) begin
            $display("Test %s: timed out waiting for ing_tready on port %0d", row_name[r], p);
            timeouts++;
        end else if (u_chk.egr_pkts[p] < target) begin
            $display("Test %s: timed out waiting for the packet on egress port %0d",
                     row_name[r], p);
            timeouts++;
        end else begin
            if (row_clear[r]) begin
                pulse_clear(p);
            end
            u_chk.report_row(row_name[r], p, row_stall[r], row_clear[r]);
        end
    endtask

    ////////////////////////////////
    // Main sequence

    initial begin
        int         first;
        int         last;
        logic [7:0] bits;
        phys_port_clk_ifc = 1'b0;
        rst_n      = 1'b0;
        ing_tvalid = '0;
        ing_tlast  = '0;
        cnt_clear  = '0;
        stall_on   = '0;
        for (int i = 0; i < NUM_PORTS; i++) begin
            ing_tdata[i] = '0;
        end
        lfsr_state = 32'h1bba201b;
        timeouts   = 0;
        nrows      = 0;

        // Rows of one batch run together and every length reaches every port
        add_row("echo_p0_len1",  0, 0, 1,  1'b0, 1'b0);
        add_row("echo_p1_len3",  0, 1, 3,  1'b0, 1'b0);
        add_row("echo_p2_len4",  0, 2, 4,  1'b0, 1'b0);
        add_row("echo_p3_len5",  0, 3, 5,  1'b0, 1'b0);
        add_row("echo_p0_len3",  1, 0, 3,  1'b0, 1'b0);
        add_row("echo_p1_len4",  1, 1, 4,  1'b0, 1'b0);
        add_row("echo_p2_len5",  1, 2, 5,  1'b0, 1'b0);
        add_row("echo_p3_len64", 1, 3, 64, 1'b0, 1'b0);
        add_row("echo_p0_len4",  2, 0, 4,  1'b0, 1'b0);
        add_row("echo_p1_len5",  2, 1, 5,  1'b0, 1'b0);
        add_row("echo_p2_len64", 2, 2, 64, 1'b0, 1'b0);
        add_row("echo_p3_len1",  2, 3, 1,  1'b0, 1'b0);
        add_row("echo_p0_len5",  3, 0, 5,  1'b0, 1'b0);
        add_row("echo_p1_len64", 3, 1, 64, 1'b0, 1'b0);
        add_row("echo_p2_len1",  3, 2, 1,  1'b0, 1'b0);
        add_row("echo_p3_len3",  3, 3, 3,  1'b0, 1'b0);
        add_row("echo_p0_len64", 4, 0, 64, 1'b0, 1'b0);
        add_row("echo_p1_len1",  4, 1, 1,  1'b0, 1'b0);
        add_row("echo_p2_len3",  4, 2, 3,  1'b0, 1'b0);
        add_row("echo_p3_len4",  4, 3, 4,  1'b0, 1'b0);
        add_row("stall_p0",      5, 0, 64, 1'b1, 1'b0);
        add_row("stall_p1",      5, 1, 48, 1'b1, 1'b0);
        add_row("stall_p2",      5, 2, 64, 1'b1, 1'b0);
        add_row("stall_p3",      5, 3, 30, 1'b1, 1'b0);
        add_row("clear_p2",      6, 2, 7,  1'b0, 1'b1);
        add_row("after_clr_p2",  7, 2, 2,  1'b0, 1'b0);
        add_row("after_clr_p0",  7, 0, 6,  1'b0, 1'b0);

        for (int r = 0; r < nrows; r++) begin
            for (int b = 0; b < row_len[r]; b++) begin
                take_bits(8, bits);
                payload[r][b] = bits;
            end
        end

        repeat (5) @(posedge phys_port_clk_ifc);
        #1;
        rst_n = 1'b1;

        first = 0;
        while (first < nrows && timeouts == 0) begin
            last = first;
            while (last < nrows && row_batch[last] == row_batch[first]) begin
                last++;
            end
            for (int r = first; r < last; r++) begin
                fork
                    automatic int rr = r;
                    run_row(rr);
                join_none
            end
            wait fork;
            @(posedge phys_port_clk_ifc);
            #1;
            first = last;
        end

        $display("Tests run %0d of %0d, failed %0d, errors %0d, timeouts %0d",
                 u_chk.tests, nrows, u_chk.failed, u_chk.errors, timeouts);
        if (u_chk.errors == 0 && timeouts == 0 && u_chk.tests == nrows) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: files.f
stream_pkg.sv
stats_pkg.sv
ing_port_packer.sv
echo_switch.sv
egr_port_unpacker.sv
port_frame_counters.sv
p4_router_top.sv
p4_router_checker.sv
p4_router_tb.sv

// File: Bender.yml
package:
  name: p4_router

sources:
  - stream_pkg.sv
  - stats_pkg.sv
  - ing_port_packer.sv
  - echo_switch.sv
  - egr_port_unpacker.sv
  - port_frame_counters.sv
  - p4_router_top.sv
  - target: simulation
    files:
      - p4_router_checker.sv
      - p4_router_tb.sv
